/* src.f */
+incdir+test
rtl/rename_pkg.sv
rtl/rat.sv
rtl/free_list.sv
rtl/rrf.sv
rtl/rename_stage.sv
rtl/rename_top.sv
test/tb_rename_top.sv

/* test/tb_rename_model.svh */
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

int m_map [32];         // speculative mapping
bit m_valid [32];
int m_rrf [32];         // committed mapping
int free_q [$];         // free tags, next to hand out first
int q_arch [$];         // renamed, uncommitted destinations, oldest first
int q_phy [$];

function automatic void reset_model();
    free_q.delete();
    q_arch.delete();
    q_phy.delete();
    for (int i = 0; i < 32; i++) begin
        m_map[i]   = i;
        m_valid[i] = 1'b1;
        m_rrf[i]   = i;
        free_q.push_back(32 + i);
    end
endfunction

function automatic void lookup_source(input int a, output int phy, output bit rdy);
    phy = m_map[a];
    rdy = m_valid[a];
    for (int j = 0; j < 2; j++) begin
        if (cdb_valid[j] && cdb_arch[j] == a && cdb_phy[j] == m_map[a])
            rdy = 1'b1;     // same-cycle broadcast
    end
    if (a == 0) begin
        phy = 0;
        rdy = 1'b1;
    end
endfunction

// renamed outputs for a group accepted at the coming edge
function automatic void predict_renamed();
    int tag [2];
    int k;
    bit r;
    bit need0;
    k = 0;
    for (int i = 0; i < 2; i++) begin
        tag[i] = 0;
        if (dec_valid[i] && dec_rd[i] != 0) begin
            tag[i] = free_q[k];
            k++;
        end
        exp_rd[i] = tag[i];
        lookup_source(dec_rs1[i], exp_rs1[i], r);
        exp_rs1_rdy[i] = r;
        lookup_source(dec_rs2[i], exp_rs2[i], r);
        exp_rs2_rdy[i] = r;
    end
    need0 = dec_valid[0] && dec_rd[0] != 0;
    // lane 1 reads what lane 0 writes
    if (need0 && dec_rs1[1] == dec_rd[0]) begin
        exp_rs1[1]     = tag[0];
        exp_rs1_rdy[1] = 1'b0;
    end
    if (need0 && dec_rs2[1] == dec_rd[0]) begin
        exp_rs2[1]     = tag[0];
        exp_rs2_rdy[1] = 1'b0;
    end
    exp_valid = dec_valid;
endfunction

// state change at one rising edge
function automatic void step_model(input bit accept, input bit flush_now);
    int t;
    for (int i = 0; i < 2; i++) begin
        if (commit_valid[i] && commit_arch[i] != 0) begin   // x0 commits free nothing
            free_q.push_back(m_rrf[commit_arch[i]]);    // old committed tag
            m_rrf[commit_arch[i]] = commit_phy[i];
            void'(q_arch.pop_front());
            void'(q_phy.pop_front());
        end
    end
    for (int j = 0; j < 2; j++) begin
        if (cdb_valid[j] && cdb_phy[j] == m_map[cdb_arch[j]])
            m_valid[cdb_arch[j]] = 1'b1;
    end
    for (int i = 0; i < 2; i++) begin
        if (accept && dec_valid[i] && dec_rd[i] != 0) begin
            t = free_q.pop_front();
            m_map[dec_rd[i]]   = t;
            m_valid[dec_rd[i]] = 1'b0;
            q_arch.push_back(dec_rd[i]);
            q_phy.push_back(t);
        end
    end
    if (flush_now) begin
        // uncommitted tags return ahead of the free ones in allocation order
        for (int k = q_phy.size() - 1; k >= 0; k--)
            free_q.push_front(q_phy[k]);
        q_arch.delete();
        q_phy.delete();
        m_map = m_rrf;
        for (int i = 0; i < 32; i++)
            m_valid[i] = 1'b1;
    end
endfunction

`endif

/* test/tb_rename_top.sv */
`timescale 1ns/1ps

module tb_rename_top;

    logic                       clk;
    logic                       rst;
    logic                       flush;
    logic [1:0]                 dec_valid;
    rename_pkg::arch_idx_t      dec_rd [2];
    rename_pkg::arch_idx_t      dec_rs1 [2];
    rename_pkg::arch_idx_t      dec_rs2 [2];
    logic                       dec_ready;
    logic [1:0]                 ren_valid;
    rename_pkg::phy_tag_t       ren_rd_phy [2];
    rename_pkg::phy_tag_t       ren_rs1_phy [2];
    logic [1:0]                 ren_rs1_ready;
    rename_pkg::phy_tag_t       ren_rs2_phy [2];
    logic [1:0]                 ren_rs2_ready;
    logic [1:0]                 cdb_valid;
    rename_pkg::arch_idx_t      cdb_arch [2];
    rename_pkg::phy_tag_t       cdb_phy [2];
    logic [1:0]                 commit_valid;
    rename_pkg::arch_idx_t      commit_arch [2];
    rename_pkg::phy_tag_t       commit_phy [2];

    logic [31:0]    lfsr;
    int             errors;
    int             checks;
    int             n;
    string          test_name;
    bit             group_live;     // decode group held until dec_ready
    bit             last_ready;
    logic [1:0]     exp_valid;
    int             exp_rd [2];
    int             exp_rs1 [2];
    int             exp_rs2 [2];
    logic [1:0]     exp_rs1_rdy;
    logic [1:0]     exp_rs2_rdy;

    `include "tb_rename_model.svh"

    rename_top i_dut (
        .clk, .rst, .flush,
        .dec_valid, .dec_rd, .dec_rs1, .dec_rs2, .dec_ready,
        .ren_valid, .ren_rd_phy, .ren_rs1_phy, .ren_rs1_ready,
        .ren_rs2_phy, .ren_rs2_ready,
        .cdb_valid, .cdb_arch, .cdb_phy,
        .commit_valid, .commit_arch, .commit_phy
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic int rand_bits(input int nbits);
        int v;
        v = 0;
        for (int k = 0; k < nbits; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic compare(input string field, input logic [31:0] expv, input logic [31:0] actv);
        checks++;
        if (actv !== expv) begin
            errors++;
            $display("ERROR %s %s: expected %0d actual %0d", test_name, field, expv, actv);
        end
    endtask

    task automatic check_renamed();
        compare("ren_valid", exp_valid, ren_valid);
        for (int i = 0; i < 2; i++) begin
            if (exp_valid[i]) begin
                compare($sformatf("ren_rd_phy[%0d]", i), exp_rd[i], ren_rd_phy[i]);
                compare($sformatf("ren_rs1_phy[%0d]", i), exp_rs1[i], ren_rs1_phy[i]);
                compare($sformatf("ren_rs1_ready[%0d]", i), exp_rs1_rdy[i], ren_rs1_ready[i]);
                compare($sformatf("ren_rs2_phy[%0d]", i), exp_rs2[i], ren_rs2_phy[i]);
                compare($sformatf("ren_rs2_ready[%0d]", i), exp_rs2_rdy[i], ren_rs2_ready[i]);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus applied at the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_inputs(input bit allow_commit, input bit do_flush);
        int k;
        int nc;
        int qi;
        if (!group_live) begin
            for (int i = 0; i < 2; i++) begin
                dec_valid[i] = rand_bits(2) != 0;
                // mostly x0..x7 so dependencies show up often
                dec_rd[i]  = rename_pkg::arch_idx_t'(rand_bits(rand_bits(2) == 0 ? 5 : 3));
                dec_rs1[i] = rename_pkg::arch_idx_t'(rand_bits(rand_bits(2) == 0 ? 5 : 3));
                dec_rs2[i] = rename_pkg::arch_idx_t'(rand_bits(rand_bits(2) == 0 ? 5 : 3));
            end
            group_live = 1'b1;
        end
        for (int j = 0; j < 2; j++) begin
            cdb_valid[j] = 1'b0;
            if (q_phy.size() > 0 && rand_bits(1) == 1) begin
                k = rand_bits(5) % q_phy.size();    // may be stale already
                cdb_valid[j] = 1'b1;
                cdb_arch[j]  = rename_pkg::arch_idx_t'(q_arch[k]);
                cdb_phy[j]   = rename_pkg::phy_tag_t'(q_phy[k]);
            end
        end
        nc = (allow_commit && !do_flush) ? rand_bits(2) : 0;
        commit_valid = '0;
        qi = 0;
        for (int i = 0; i < 2; i++) begin
            if (i < nc) begin
                if (qi < q_phy.size() && rand_bits(3) != 0) begin
                    commit_valid[i] = 1'b1;
                    commit_arch[i]  = rename_pkg::arch_idx_t'(q_arch[qi]);
                    commit_phy[i]   = rename_pkg::phy_tag_t'(q_phy[qi]);
                    qi++;
                end else if (rand_bits(2) == 0) begin
                    // an op without a destination retires too
                    commit_valid[i] = 1'b1;
                    commit_arch[i]  = '0;
                    commit_phy[i]   = rename_pkg::phy_tag_t'(rand_bits(6));
                end
            end
        end
        flush = do_flush;
    endtask

    // starts and ends at a falling edge
    task automatic run_cycle(input bit allow_commit, input bit do_flush);
        int need;
        check_renamed();
        drive_inputs(allow_commit, do_flush);
        #1;
        need = 0;
        for (int i = 0; i < 2; i++) begin
            if (dec_valid[i] && dec_rd[i] != 0)
                need++;
        end
        last_ready = !do_flush && free_q.size() >= need;
        compare("dec_ready", last_ready, dec_ready);
        exp_valid = '0;
        if (last_ready) begin
            predict_renamed();
            group_live = 1'b0;
        end
        step_model(last_ready, do_flush);
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        lfsr         = 32'hb402;
        errors       = 0;
        checks       = 0;
        group_live   = 1'b0;
        last_ready   = 1'b0;
        exp_valid    = '0;
        rst          = 1'b1;
        flush        = 1'b0;
        dec_valid    = '0;
        cdb_valid    = '0;
        commit_valid = '0;
        for (int i = 0; i < 2; i++) begin
            dec_rd[i]      = '0;
            dec_rs1[i]     = '0;
            dec_rs2[i]     = '0;
            cdb_arch[i]    = '0;
            cdb_phy[i]     = '0;
            commit_arch[i] = '0;
            commit_phy[i]  = '0;
        end
        reset_model();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "random";       // first groups get tags 32 and up
        repeat (400) run_cycle(1'b1, rand_bits(5) == 0);

        test_name = "fill";
        n = 0;
        last_ready = 1'b1;
        while (last_ready && n < 200) begin
            run_cycle(1'b0, 1'b0);
            n++;
        end
        if (last_ready) begin
            errors++;
            $display("fill: dec_ready stayed high for 200 cycles without any commit");
        end

        test_name = "drain";
        n = 0;
        while (!last_ready && n < 50) begin
            run_cycle(1'b1, 1'b0);
            n++;
        end
        if (!last_ready) begin
            errors++;
            $display("drain: renaming did not resume within 50 cycles of commits");
        end
        repeat (40) run_cycle(1'b1, 1'b0);

        test_name = "flush";
        run_cycle(1'b0, 1'b1);
        repeat (40) run_cycle(1'b1, 1'b0);

        test_name = "random_flush";
        repeat (300) run_cycle(1'b1, rand_bits(3) == 0);
        check_renamed();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* rtl/rename_top.sv */
`timescale 1ns/1ps

module rename_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    input  logic [rename_pkg::ID_WIDTH-1:0]     dec_valid,
    input  rename_pkg::arch_idx_t               dec_rd [rename_pkg::ID_WIDTH],
    input  rename_pkg::arch_idx_t               dec_rs1 [rename_pkg::ID_WIDTH],
    input  rename_pkg::arch_idx_t               dec_rs2 [rename_pkg::ID_WIDTH],
    output logic                                dec_ready,

    output logic [rename_pkg::ID_WIDTH-1:0]     ren_valid,
    output rename_pkg::phy_tag_t                ren_rd_phy [rename_pkg::ID_WIDTH],
    output rename_pkg::phy_tag_t                ren_rs1_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     ren_rs1_ready,
    output rename_pkg::phy_tag_t                ren_rs2_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     ren_rs2_ready,

    input  logic [rename_pkg::CDB_WIDTH-1:0]    cdb_valid,
    input  rename_pkg::arch_idx_t               cdb_arch [rename_pkg::CDB_WIDTH],
    input  rename_pkg::phy_tag_t                cdb_phy [rename_pkg::CDB_WIDTH],

    input  logic [rename_pkg::ID_WIDTH-1:0]     commit_valid,   // oldest in lane 0
    input  rename_pkg::arch_idx_t               commit_arch [rename_pkg::ID_WIDTH],
    input  rename_pkg::phy_tag_t                commit_phy [rename_pkg::ID_WIDTH]
);

    logic [rename_pkg::ID_WIDTH-1:0]    alloc_en;
    rename_pkg::phy_tag_t               alloc_phy [rename_pkg::ID_WIDTH];
    logic [rename_pkg::FL_IDX:0]        free_count;

    logic [rename_pkg::ID_WIDTH-1:0]    rat_we;
    rename_pkg::arch_idx_t              rat_rd_arch [rename_pkg::ID_WIDTH];
    rename_pkg::phy_tag_t               rat_rd_phy [rename_pkg::ID_WIDTH];
    rename_pkg::arch_idx_t              rat_rs1_arch [rename_pkg::ID_WIDTH];
    rename_pkg::arch_idx_t              rat_rs2_arch [rename_pkg::ID_WIDTH];
    rename_pkg::phy_tag_t               rat_rs1_phy [rename_pkg::ID_WIDTH];
    rename_pkg::phy_tag_t               rat_rs2_phy [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ID_WIDTH-1:0]    rat_rs1_valid;
    logic [rename_pkg::ID_WIDTH-1:0]    rat_rs2_valid;

    logic [rename_pkg::ID_WIDTH-1:0]    free_en;
    rename_pkg::phy_tag_t               free_phy [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ID_WIDTH-1:0]    commit_adv;
    rename_pkg::phy_tag_t               rrf_mem [rename_pkg::ARF_DEPTH];

    rename_stage i_rename_stage (
        .clk, .rst, .flush,
        .dec_valid, .dec_rd, .dec_rs1, .dec_rs2, .dec_ready,
        .alloc_phy, .free_count, .alloc_en,
        .rat_rs1_arch, .rat_rs2_arch, .rat_rs1_phy, .rat_rs2_phy,
        .rat_rs1_valid, .rat_rs2_valid,
        .rat_we, .rat_rd_arch, .rat_rd_phy,
        .ren_valid, .ren_rd_phy, .ren_rs1_phy, .ren_rs1_ready,
        .ren_rs2_phy, .ren_rs2_ready
    );

    rat i_rat (
        .clk, .rst, .flush, .rrf_mem,
        .we        (rat_we),
        .wr_arch   (rat_rd_arch),
        .wr_phy    (rat_rd_phy),
        .rs1_arch  (rat_rs1_arch),
        .rs2_arch  (rat_rs2_arch),
        .rs1_phy   (rat_rs1_phy),
        .rs2_phy   (rat_rs2_phy),
        .rs1_valid (rat_rs1_valid),
        .rs2_valid (rat_rs2_valid),
        .cdb_valid, .cdb_arch, .cdb_phy
    );

    free_list i_free_list (
        .clk, .rst, .flush,
        .alloc_en, .alloc_phy, .free_count,
        .free_en, .free_phy, .commit_adv
    );

    rrf i_rrf (
        .clk, .rst,
        .commit_valid, .commit_arch, .commit_phy,
        .rrf_mem, .free_en, .free_phy, .commit_adv
    );

endmodule

/* rtl/rename_stage.sv */
`timescale 1ns/1ps

module rename_stage (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    input  logic [rename_pkg::ID_WIDTH-1:0]     dec_valid,
    input  rename_pkg::arch_idx_t               dec_rd [rename_pkg::ID_WIDTH],
    input  rename_pkg::arch_idx_t               dec_rs1 [rename_pkg::ID_WIDTH],
    input  rename_pkg::arch_idx_t               dec_rs2 [rename_pkg::ID_WIDTH],
    output logic                                dec_ready,

    input  rename_pkg::phy_tag_t                alloc_phy [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::FL_IDX:0]         free_count,
    output logic [rename_pkg::ID_WIDTH-1:0]     alloc_en,

    output rename_pkg::arch_idx_t               rat_rs1_arch [rename_pkg::ID_WIDTH],
    output rename_pkg::arch_idx_t               rat_rs2_arch [rename_pkg::ID_WIDTH],
    input  rename_pkg::phy_tag_t                rat_rs1_phy [rename_pkg::ID_WIDTH],
    input  rename_pkg::phy_tag_t                rat_rs2_phy [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::ID_WIDTH-1:0]     rat_rs1_valid,
    input  logic [rename_pkg::ID_WIDTH-1:0]     rat_rs2_valid,

    output logic [rename_pkg::ID_WIDTH-1:0]     rat_we,
    output rename_pkg::arch_idx_t               rat_rd_arch [rename_pkg::ID_WIDTH],
    output rename_pkg::phy_tag_t                rat_rd_phy [rename_pkg::ID_WIDTH],

    output logic [rename_pkg::ID_WIDTH-1:0]     ren_valid,
    output rename_pkg::phy_tag_t                ren_rd_phy [rename_pkg::ID_WIDTH],
    output rename_pkg::phy_tag_t                ren_rs1_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     ren_rs1_ready,
    output rename_pkg::phy_tag_t                ren_rs2_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     ren_rs2_ready
);

    logic [rename_pkg::ID_WIDTH-1:0]    need;       // lane writes a nonzero rd
    logic [1:0]                         need_cnt;
    rename_pkg::phy_tag_t               new_tag [rename_pkg::ID_WIDTH];
    rename_pkg::phy_tag_t               rs1_phy_c [rename_pkg::ID_WIDTH];
    rename_pkg::phy_tag_t               rs2_phy_c [rename_pkg::ID_WIDTH];
    logic [rename_pkg::ID_WIDTH-1:0]    rs1_rdy_c;
    logic [rename_pkg::ID_WIDTH-1:0]    rs2_rdy_c;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // allocation and stall
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            need[i] = dec_valid[i] && dec_rd[i] != '0;
        end
    end

    assign need_cnt  = 2'(need[0]) + 2'(need[1]);
    assign dec_ready = !flush && free_count >= (rename_pkg::FL_IDX+1)'(need_cnt);
    assign alloc_en  = need & {rename_pkg::ID_WIDTH{dec_ready}};

    assign new_tag[0] = alloc_phy[0];
    assign new_tag[1] = need[0] ? alloc_phy[1] : alloc_phy[0];    // second tag only if shared

    assign rat_we       = alloc_en;
    assign rat_rd_arch  = dec_rd;
    assign rat_rd_phy   = new_tag;
    assign rat_rs1_arch = dec_rs1;
    assign rat_rs2_arch = dec_rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // intra-group bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        rs1_phy_c = rat_rs1_phy;
        rs2_phy_c = rat_rs2_phy;
        rs1_rdy_c = rat_rs1_valid;
        rs2_rdy_c = rat_rs2_valid;
        if (need[0] && dec_rs1[1] == dec_rd[0]) begin
            rs1_phy_c[1] = new_tag[0];
            rs1_rdy_c[1] = 1'b0;
        end
        if (need[0] && dec_rs2[1] == dec_rd[0]) begin
            rs2_phy_c[1] = new_tag[0];
            rs2_rdy_c[1] = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // renamed op register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst)
            ren_valid <= '0;
        else
            ren_valid <= dec_valid & {rename_pkg::ID_WIDTH{dec_ready}};
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            ren_rd_phy[i] <= need[i] ? new_tag[i] : '0;     // x0 reports tag 0
        end
        ren_rs1_phy   <= rs1_phy_c;
        ren_rs2_phy   <= rs2_phy_c;
        ren_rs1_ready <= rs1_rdy_c;
        ren_rs2_ready <= rs2_rdy_c;
    end

endmodule

/* rtl/rrf.sv */
`timescale 1ns/1ps

module rrf (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [rename_pkg::ID_WIDTH-1:0]     commit_valid,
    input  rename_pkg::arch_idx_t               commit_arch [rename_pkg::ID_WIDTH],
    input  rename_pkg::phy_tag_t                commit_phy [rename_pkg::ID_WIDTH],

    output rename_pkg::phy_tag_t                rrf_mem [rename_pkg::ARF_DEPTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     free_en,
    output rename_pkg::phy_tag_t                free_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]     commit_adv
);

    rename_pkg::phy_tag_t   mem [rename_pkg::ARF_DEPTH];
    logic                   same_rd;

    assign rrf_mem = mem;

    // x0 commits carry no tag
    always_comb begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            free_en[i] = commit_valid[i] && commit_arch[i] != '0;
        end
    end

    assign commit_adv = free_en;
    assign same_rd    = free_en[0] && free_en[1] && commit_arch[0] == commit_arch[1];

    // lane 1 replaces lane 0's mapping when both hit one register
    assign free_phy[0] = mem[commit_arch[0]];
    assign free_phy[1] = same_rd ? commit_phy[0] : mem[commit_arch[1]];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
                mem[i] <= rename_pkg::phy_tag_t'(i);
            end
        end else begin
            for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
                if (free_en[i])
                    mem[commit_arch[i]] <= commit_phy[i];
            end
        end
    end

endmodule

/* rtl/free_list.sv */
`timescale 1ns/1ps

module free_list (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,

    input  logic [rename_pkg::ID_WIDTH-1:0]     alloc_en,
    output rename_pkg::phy_tag_t                alloc_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::FL_IDX:0]         free_count,

    input  logic [rename_pkg::ID_WIDTH-1:0]     free_en,
    input  rename_pkg::phy_tag_t                free_phy [rename_pkg::ID_WIDTH],
    input  logic [rename_pkg::ID_WIDTH-1:0]     commit_adv
);

    rename_pkg::phy_tag_t   mem [rename_pkg::FREE_DEPTH];

    rename_pkg::fl_ptr_t    alloc_head;
    rename_pkg::fl_ptr_t    commit_head;
    rename_pkg::fl_ptr_t    tail;

    rename_pkg::fl_ptr_t    alloc_head_p1;
    rename_pkg::fl_ptr_t    tail_p1;
    rename_pkg::fl_ptr_t    commit_head_nxt;

    logic [1:0]             n_alloc;
    logic [1:0]             n_free;
    logic [1:0]             n_commit;

    assign n_alloc  = 2'(alloc_en[0]) + 2'(alloc_en[1]);
    assign n_free   = 2'(free_en[0]) + 2'(free_en[1]);
    assign n_commit = 2'(commit_adv[0]) + 2'(commit_adv[1]);

    assign alloc_head_p1   = alloc_head + rename_pkg::fl_ptr_t'(1);
    assign tail_p1         = tail + rename_pkg::fl_ptr_t'(1);
    assign commit_head_nxt = commit_head + rename_pkg::fl_ptr_t'(n_commit);

    // wrap bit makes a full list read 32 rather than 0
    assign free_count = tail - alloc_head;

    assign alloc_phy[0] = mem[alloc_head[rename_pkg::FL_IDX-1:0]];
    assign alloc_phy[1] = mem[alloc_head_p1[rename_pkg::FL_IDX-1:0]];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tag storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                mem[i] <= rename_pkg::phy_tag_t'(rename_pkg::ARF_DEPTH + i);
            end
        end else begin
            if (free_en[0])
                mem[tail[rename_pkg::FL_IDX-1:0]] <= free_phy[0];
            if (free_en[1] && free_en[0])
                mem[tail_p1[rename_pkg::FL_IDX-1:0]] <= free_phy[1];
            else if (free_en[1])
                mem[tail[rename_pkg::FL_IDX-1:0]] <= free_phy[1];   // lane 1 alone
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_head  <= '0;
            commit_head <= '0;
            tail        <= rename_pkg::fl_ptr_t'(rename_pkg::FREE_DEPTH);
        end else begin
            commit_head <= commit_head_nxt;
            tail        <= tail + rename_pkg::fl_ptr_t'(n_free);
            if (flush)
                alloc_head <= commit_head_nxt;      // drop uncommitted allocations
            else
                alloc_head <= alloc_head + rename_pkg::fl_ptr_t'(n_alloc);
        end
    end

endmodule

/* rtl/rat.sv */
`timescale 1ns/1ps

module rat (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 flush,
    input  rename_pkg::phy_tag_t                 rrf_mem [rename_pkg::ARF_DEPTH],

    input  logic [rename_pkg::ID_WIDTH-1:0]      we,
    input  rename_pkg::arch_idx_t                wr_arch [rename_pkg::ID_WIDTH],
    input  rename_pkg::phy_tag_t                 wr_phy [rename_pkg::ID_WIDTH],

    input  rename_pkg::arch_idx_t                rs1_arch [rename_pkg::ID_WIDTH],
    input  rename_pkg::arch_idx_t                rs2_arch [rename_pkg::ID_WIDTH],
    output rename_pkg::phy_tag_t                 rs1_phy [rename_pkg::ID_WIDTH],
    output rename_pkg::phy_tag_t                 rs2_phy [rename_pkg::ID_WIDTH],
    output logic [rename_pkg::ID_WIDTH-1:0]      rs1_valid,
    output logic [rename_pkg::ID_WIDTH-1:0]      rs2_valid,

    input  logic [rename_pkg::CDB_WIDTH-1:0]     cdb_valid,
    input  rename_pkg::arch_idx_t                cdb_arch [rename_pkg::CDB_WIDTH],
    input  rename_pkg::phy_tag_t                 cdb_phy [rename_pkg::CDB_WIDTH]
);

    rename_pkg::phy_tag_t                map [rename_pkg::ARF_DEPTH];
    logic [rename_pkg::ARF_DEPTH-1:0]    valid;     // value written to the prf

    // a broadcast only counts while its tag is still the current mapping
    function automatic logic cdb_hit(input rename_pkg::arch_idx_t a);
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < rename_pkg::CDB_WIDTH; j++) begin
            if (cdb_valid[j] && cdb_arch[j] == a && map[a] == cdb_phy[j])
                hit = 1'b1;
        end
        return hit;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // table update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARF_DEPTH; i++) begin
                map[i] <= rename_pkg::phy_tag_t'(i);    // identity
            end
            valid <= '1;
        end else if (flush) begin
            map   <= rrf_mem;
            valid <= '1;
        end else begin
            for (int j = 0; j < rename_pkg::CDB_WIDTH; j++) begin
                if (cdb_valid[j] && map[cdb_arch[j]] == cdb_phy[j])
                    valid[cdb_arch[j]] <= 1'b1;
            end
            // lane 1 last, so it wins on a shared rd
            for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
                if (we[i]) begin
                    map[wr_arch[i]]   <= wr_phy[i];
                    valid[wr_arch[i]] <= 1'b0;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source lookup, transparent to the cdb
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int i = 0; i < rename_pkg::ID_WIDTH; i++) begin
            rs1_phy[i]   = map[rs1_arch[i]];
            rs2_phy[i]   = map[rs2_arch[i]];
            rs1_valid[i] = valid[rs1_arch[i]] || cdb_hit(rs1_arch[i]);
            rs2_valid[i] = valid[rs2_arch[i]] || cdb_hit(rs2_arch[i]);

            if (rs1_arch[i] == '0) begin    // x0 is hardwired
                rs1_phy[i]   = '0;
                rs1_valid[i] = 1'b1;
            end
            if (rs2_arch[i] == '0) begin
                rs2_phy[i]   = '0;
                rs2_valid[i] = 1'b1;
            end
        end
    end

endmodule

/* rtl/rename_pkg.sv */
package rename_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ARF_DEPTH = 32;
    localparam int ARF_IDX   = 5;
    localparam int PRF_DEPTH = 64;
    localparam int PRF_IDX   = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ID_WIDTH  = 2;   // rename lanes
    localparam int CDB_WIDTH = 2;   // result buses

    // tags not held by an architectural register at reset
    localparam int FREE_DEPTH = PRF_DEPTH - ARF_DEPTH;
    localparam int FL_IDX     = $clog2(FREE_DEPTH);

    typedef logic [ARF_IDX-1:0] arch_idx_t;
    typedef logic [PRF_IDX-1:0] phy_tag_t;
    typedef logic [FL_IDX:0]    fl_ptr_t;   // msb is the wrap bit

endpackage
